//--- files.f
logic/ps2LinePkg.sv
logic/ps2RegPkg.sv
logic/ps2LineFilter.sv
logic/ps2FrameReceiver.sv
logic/ps2FrameTransmitter.sv
logic/ps2Fifo.sv
logic/ps2Port.sv
verification/ps2DeviceModel.sv
verification/ps2PortTb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= files.f
TB_TOP ?= ps2PortTb
RTL_TOP ?= ps2Port
BUILD_DIR ?= obj_dir
LOG ?= sim.log
RTL_SRCS ?= $(filter logic/%,$(shell cat $(FILELIST)))
LINT_FLAGS ?= --timescale 1ns/1ns
SIM_FLAGS ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_MSG := Everything OK
FAIL_MSG := Something failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: FAIL, no pass line"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/ps2PortTb.sv
`timescale 1ns/1ns
`default_nettype none

module ps2PortTb
	import ps2LinePkg::*, ps2RegPkg::*;
();

	localparam int fifoAddrBits = 2;
	localparam int depth = 2 ** fifoAddrBits;
	localparam int inhibitCycles = 40;
	localparam int halfPeriod = 20;
	localparam int clkPeriod = 40;
	// Frames on the line over the whole run in both directions
	localparam int frameCount = 15;
	localparam int frameNs = 11 * 2 * halfPeriod * clkPeriod;
	localparam int timeoutNs = frameCount * frameNs * 2 + 100000;
	localparam logic [fifoAddrBits:0] fullLoad = (fifoAddrBits + 1)'(depth);

	logic clk;
	logic rst;
	busWord din;
	byteEnable we;
	logic en;
	logic sel;
	ps2Byte datRegOut;
	busWord ctrlRegOut;
	logic interrupt;
	logic ps2ClkLow;
	logic ps2DatLow;
	logic devClk;
	logic devDat;
	logic lineClk;
	logic lineDat;
	logic hostClocking;
	logic capValid;
	ps2Byte capByte;
	logic capParity;
	logic capStop;

	// Scoreboard and check points
	ps2Byte rxQueue[$];
	ps2Byte txQueue[$];
	ps2Byte expRx;
	ps2Byte expTx;
	logic ctrlCheck;
	busWord ctrlMask;
	busWord ctrlExp;
	logic dataRead;
	logic [fifoAddrBits:0] rxLoad;
	logic [fifoAddrBits:0] loadPrev;
	logic intPrev;
	logic intEnModel;
	logic intEnPrev;
	int errorCount;
	integer seed;

	// Wired-AND of the open drain lines
	assign lineClk = devClk & ~ps2ClkLow;
	assign lineDat = devDat & ~ps2DatLow;
	assign dataRead = en && (we == 4'b0000) && !sel;
	assign rxLoad = ctrlRegOut[ctrlRxLoadLsb +: fifoAddrBits + 1];

	ps2Port #(
		.fifoAddrBits(fifoAddrBits),
		.inhibitCycles(inhibitCycles)
	) u_dut (
		.clk(clk), .rst(rst), .din(din), .we(we), .en(en), .sel(sel),
		.ps2Clk(lineClk), .ps2Dat(lineDat), .datRegOut(datRegOut),
		.ctrlRegOut(ctrlRegOut), .interrupt(interrupt),
		.ps2ClkLow(ps2ClkLow), .ps2DatLow(ps2DatLow)
	);

	ps2DeviceModel #(.halfPeriod(halfPeriod)) devModel (
		.clk(clk), .lineClk(lineClk), .lineDat(lineDat), .devClk(devClk),
		.devDat(devDat), .hostClocking(hostClocking), .capValid(capValid),
		.capByte(capByte), .capParity(capParity), .capStop(capStop)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Previous cycle view of load and interrupt
	always @(posedge clk)
	begin
		loadPrev <= rxLoad;
		intPrev <= interrupt;
		intEnPrev <= intEnModel;
	end

	task automatic reportMismatch(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		errorCount = errorCount + 1;
		$display("[ERROR] %s = 0x%h, expected 0x%h", name, actual, expected);
	endtask

	task automatic reportFailure(input string what);
		errorCount = errorCount + 1;
		$display("Check failed: %s", what);
	endtask

	////////////////////////////////////////
	// Assertions
	////////////////////////////////////////

	// Read returns the oldest queued byte
	readHead: assert property (@(posedge clk) disable iff (rst) dataRead |-> datRegOut == expRx)
		else reportMismatch("datRegOut", 32'($sampled(datRegOut)), 32'(expRx));
	readPop: assert property (@(posedge clk) disable iff (rst)
		dataRead |=> rxLoad == loadPrev - 1'b1)
		else reportMismatch("rxLoad", 32'($sampled(rxLoad)), 32'($sampled(loadPrev) - 1'b1));
	// Pulse per push only while enabled
	pushInt: assert property (@(posedge clk) disable iff (rst)
		rxLoad == loadPrev + 1'b1 |-> intPrev == intEnPrev)
		else reportMismatch("interrupt", 32'($sampled(intPrev)), 32'($sampled(intEnPrev)));
	fullInt: assert property (@(posedge clk) disable iff (rst) rxLoad == fullLoad |-> interrupt)
		else reportMismatch("interrupt", 32'($sampled(interrupt)), 32'h1);
	spuriousInt: assert property (@(posedge clk) disable iff (rst)
		interrupt && rxLoad != fullLoad |=> rxLoad == loadPrev + 1'b1)
		else reportFailure("interrupt high without a received byte");
	// Host frames at the device
	txByte: assert property (@(posedge clk) disable iff (rst) capValid |-> capByte == expTx)
		else reportMismatch("capByte", 32'($sampled(capByte)), 32'(expTx));
	txParity: assert property (@(posedge clk) disable iff (rst) capValid |-> ^{capByte, capParity})
		else reportMismatch("capParity", 32'($sampled(capParity)), 32'(~^$sampled(capByte)));
	txStop: assert property (@(posedge clk) disable iff (rst) capValid |-> capStop)
		else reportMismatch("capStop", 32'($sampled(capStop)), 32'h1);
	clkHold: assert property (@(posedge clk) disable iff (rst) hostClocking |-> !ps2ClkLow)
		else reportFailure("host pulled the clock low while the device was clocking");
	ctrlValue: assert property (@(posedge clk) disable iff (rst)
		ctrlCheck |-> (ctrlRegOut & ctrlMask) == ctrlExp)
		else reportMismatch("ctrlRegOut", $sampled(ctrlRegOut) & ctrlMask, ctrlExp);

	////////////////////////////////////////
	// Bus and line stimulus
	////////////////////////////////////////

	function automatic ps2Byte randomByte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic writeData(input ps2Byte data);
		din = {24'h0, data};
		we = 4'b0001;
		sel = 1'b0;
		en = 1'b1;
		txQueue.push_back(data);
		@(negedge clk);
		en = 1'b0;
		we = 4'b0000;
	endtask

	task automatic writeCtrl(input busWord data, input byteEnable enables);
		din = data;
		we = enables;
		sel = 1'b1;
		en = 1'b1;
		@(negedge clk);
		en = 1'b0;
		we = 4'b0000;
		sel = 1'b0;
		// Interrupt enable now follows the written bit
		if (enables[3])
			intEnModel = data[ctrlIntEnBit];
	endtask

	task automatic readData();
		expRx = rxQueue.pop_front();
		we = 4'b0000;
		sel = 1'b0;
		en = 1'b1;
		@(negedge clk);
		en = 1'b0;
	endtask

	task automatic drainRx();
		while (rxQueue.size() > 0)
			readData();
	endtask

	task automatic checkCtrl(input busWord mask, input busWord value);
		ctrlMask = mask;
		ctrlExp = value;
		ctrlCheck = 1'b1;
		@(negedge clk);
		ctrlCheck = 1'b0;
	endtask

	// Wait until the RX fill count reaches n
	task automatic waitLoad(input int n);
		while (rxLoad != (fifoAddrBits + 1)'(n))
			@(negedge clk);
	endtask

	// Good frame; a full FIFO drops it
	task automatic receiveGood(input ps2Byte data);
		devModel.sendFrame(data, 1'b0, 1'b0);
		if (rxQueue.size() < depth)
			rxQueue.push_back(data);
	endtask

	initial
	begin
		seed = 32'hc807;
		errorCount = 0;
		rst = 1'b1;
		din = '0;
		we = '0;
		en = 1'b0;
		sel = 1'b0;
		ctrlCheck = 1'b0;
		ctrlMask = '0;
		ctrlExp = '0;
		expRx = '0;
		expTx = '0;
		intEnModel = 1'b1;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		// After reset only intEn set
		checkCtrl(32'hffff_ffff, 32'h8000_0000);

		// Received bytes in order
		for (int i = 0; i < 3; i++)
			receiveGood(randomByte());
		waitLoad(3);
		drainRx();

		// Bad parity, then bad stop, neither queued
		devModel.sendFrame(randomByte(), 1'b1, 1'b0);
		checkCtrl(32'h0007_0007, 32'h0001_0000);
		devModel.sendFrame(randomByte(), 1'b0, 1'b1);
		checkCtrl(32'h0007_0007, 32'h0003_0000);
		writeCtrl(32'h0007_0000, 4'b0100);
		checkCtrl(32'h8007_0000, 32'h8000_0000);

		// Host transmit
		for (int i = 0; i < 3; i++)
			writeData(randomByte());
		while (txQueue.size() > 0)
		begin
			expTx = txQueue.pop_front();
			devModel.acceptFrame();
		end
		checkCtrl(32'h0000_0700, 32'h0000_0000);

		// Interrupt disabled for two bytes
		writeCtrl(32'h0000_0000, 4'b1000);
		checkCtrl(32'h8000_0000, 32'h0000_0000);
		receiveGood(randomByte());
		receiveGood(randomByte());
		waitLoad(2);
		drainRx();
		writeCtrl(32'h8000_0000, 4'b1000);
		checkCtrl(32'h8000_0000, 32'h8000_0000);

		// Overrun with one frame past full
		for (int i = 0; i < depth + 1; i++)
			receiveGood(randomByte());
		waitLoad(depth);
		checkCtrl(32'h0007_0007, 32'h0004_0004);
		drainRx();
		writeCtrl(32'h0007_0000, 4'b0100);
		checkCtrl(32'hffff_ffff, 32'h8000_0000);

		$display("Checks failed: %0d", errorCount);
		if (errorCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(timeoutNs);
		$display("Timeout: the run did not finish within %0d ns", timeoutNs);
		$display("Checks failed: %0d", errorCount);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/ps2DeviceModel.sv
`timescale 1ns/1ns
`default_nettype none

module ps2DeviceModel
	import ps2LinePkg::*;
#(
	parameter int halfPeriod = 20
)(
	input logic clk,
	input logic lineClk,
	input logic lineDat,
	output logic devClk,
	output logic devDat,
	output logic hostClocking,
	output logic capValid,
	output ps2Byte capByte,
	output logic capParity,
	output logic capStop
);

	// Lines released, nothing captured yet
	initial
	begin
		devClk = 1'b1;
		devDat = 1'b1;
		hostClocking = 1'b0;
		capValid = 1'b0;
		capByte = '0;
		capParity = 1'b0;
		capStop = 1'b0;
	end

	// Half a PS/2 clock period in clk cycles
	task automatic halfWait();
		repeat (halfPeriod) @(negedge clk);
	endtask

	// One clock pulse, data sampled just before the rising edge
	task automatic clockPulse(output logic sampled);
		halfWait();
		devClk = 1'b0;
		halfWait();
		sampled = lineDat;
		devClk = 1'b1;
	endtask

	////////////////////////////////////////
	// Device to host frame
	////////////////////////////////////////

	task automatic sendFrame(input ps2Byte data, input logic badParity, input logic badStop);
		logic [10:0] frame;
		logic unused;
		// Start, data LSB first, odd parity, stop
		frame = {~badStop, (~^data) ^ badParity, data, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			// Data changes while the clock is high
			devDat = frame[i];
			clockPulse(unused);
		end
		devDat = 1'b1;
		// Idle gap before the next frame
		halfWait();
	endtask

	////////////////////////////////////////
	// Host to device frame
	////////////////////////////////////////

	task automatic acceptFrame();
		logic [9:0] bits;
		logic sample;
		// Request to send: clock released, data held low by the host
		@(negedge clk);
		while (!(lineClk && !lineDat))
			@(negedge clk);
		hostClocking = 1'b1;
		// Eight data bits, parity, stop
		for (int i = 0; i < 10; i++)
		begin
			clockPulse(sample);
			bits[i] = sample;
		end
		// Acknowledge: data low across one more pulse
		devDat = 1'b0;
		clockPulse(sample);
		devDat = 1'b1;
		hostClocking = 1'b0;
		capByte = bits[7:0];
		capParity = bits[8];
		capStop = bits[9];
		capValid = 1'b1;
		@(negedge clk);
		capValid = 1'b0;
		halfWait();
	endtask

endmodule

`default_nettype wire

//--- logic/ps2Port.sv
`timescale 1ns/1ns
`default_nettype none

module ps2Port
	import ps2LinePkg::*, ps2RegPkg::*;
#(
	parameter int fifoAddrBits = 5,
	parameter int filterLength = 4,
	parameter int inhibitCycles = 2500
)(
	input logic clk,
	input logic rst,
	input busWord din,
	input byteEnable we,
	input logic en,
	input logic sel,
	input logic ps2Clk,
	input logic ps2Dat,
	output ps2Byte datRegOut,
	output busWord ctrlRegOut,
	output logic interrupt,
	output logic ps2ClkLow,
	output logic ps2DatLow
);

	logic clkLevel;
	logic datLevel;
	logic fallStrobe;
	ps2Byte rxByte;
	logic rxStrobe;
	logic parityStrobe;
	logic framingStrobe;
	ps2Byte txHead;
	logic txBusy;
	logic txEmpty;
	logic rxFull;
	logic [fifoAddrBits:0] rxCount;
	logic [fifoAddrBits:0] txCount;
	logic dataWrite;
	logic dataRead;
	logic sendStrobe;
	logic sendPrev;
	logic intEn;
	ps2ErrFlags errFlags;

	////////////////////////////////////////
	// Bus decode
	////////////////////////////////////////

	// Data register, sel low
	assign dataWrite = en && we[0] && !sel;
	assign dataRead = en && (we == '0) && !sel;

	always_ff @(posedge clk)
	begin
		if (rst)
			intEn <= 1'b1;
		else if (en && sel && we[3])
			intEn <= din[ctrlIntEnBit];
	end

	// Sticky flags, a new event beats a clear
	always_ff @(posedge clk)
	begin
		if (rst)
			errFlags <= '0;
		else
		begin
			if (en && sel && we[2])
				errFlags <= errFlags & ~din[ctrlErrLsb +: 3];
			if (parityStrobe)
				errFlags[errParityBit] <= 1'b1;
			if (framingStrobe)
				errFlags[errFramingBit] <= 1'b1;
			// Byte dropped by a full RX FIFO
			if (rxStrobe && rxFull)
				errFlags[errOverrunBit] <= 1'b1;
		end
	end

	// Back to back sends blocked until txBusy rises
	always_ff @(posedge clk)
	begin
		if (rst)
			sendPrev <= 1'b0;
		else
			sendPrev <= sendStrobe;
	end
	assign sendStrobe = !txEmpty && !txBusy && !sendPrev;

	assign interrupt = (intEn && rxStrobe) || rxFull;

	// Control word, unused bits zero
	always_comb
	begin
		ctrlRegOut = '0;
		ctrlRegOut[ctrlRxLoadLsb +: fifoAddrBits + 1] = rxCount;
		ctrlRegOut[ctrlTxLoadLsb +: fifoAddrBits + 1] = txCount;
		ctrlRegOut[ctrlErrLsb +: 3] = errFlags;
		ctrlRegOut[ctrlIntEnBit] = intEn;
	end

	////////////////////////////////////////
	// Stages
	////////////////////////////////////////

	ps2LineFilter #(.filterLength(filterLength)) u_filter (
		.clk(clk), .rst(rst), .ps2Clk(ps2Clk), .ps2Dat(ps2Dat),
		.clkLevel(clkLevel), .datLevel(datLevel), .fallStrobe(fallStrobe)
	);

	ps2FrameReceiver u_receiver (
		.clk(clk), .rst(rst), .fallStrobe(fallStrobe), .datLevel(datLevel),
		.txBusy(txBusy), .rxByte(rxByte), .rxStrobe(rxStrobe),
		.parityStrobe(parityStrobe), .framingStrobe(framingStrobe)
	);

	ps2FrameTransmitter #(.inhibitCycles(inhibitCycles)) u_transmitter (
		.clk(clk), .rst(rst), .sendStrobe(sendStrobe), .txByte(txHead),
		.fallStrobe(fallStrobe), .clkLevel(clkLevel), .datLevel(datLevel),
		.ps2ClkLow(ps2ClkLow), .ps2DatLow(ps2DatLow), .txBusy(txBusy)
	);

	// Device to host bytes, read through the data register
	ps2Fifo #(.fifoAddrBits(fifoAddrBits)) rxFifo (
		.clk(clk), .rst(rst), .din(rxByte), .push(rxStrobe), .pop(dataRead),
		.dout(datRegOut), .count(rxCount), .full(rxFull), .empty()
	);

	// Host to device bytes, written through the data register
	ps2Fifo #(.fifoAddrBits(fifoAddrBits)) txFifo (
		.clk(clk), .rst(rst), .din(din[7:0]), .push(dataWrite), .pop(sendStrobe),
		.dout(txHead), .count(txCount), .full(), .empty(txEmpty)
	);

endmodule

`default_nettype wire

//--- logic/ps2Fifo.sv
`timescale 1ns/1ns
`default_nettype none

module ps2Fifo
	import ps2LinePkg::*;
#(
	parameter int fifoAddrBits = 5
)(
	input logic clk,
	input logic rst,
	input ps2Byte din,
	input logic push,
	input logic pop,
	output ps2Byte dout,
	output logic [fifoAddrBits:0] count,
	output logic full,
	output logic empty
);

	localparam int depth = 2 ** fifoAddrBits;

	ps2Byte mem [depth];
	logic [fifoAddrBits-1:0] wrPtr;
	logic [fifoAddrBits-1:0] rdPtr;
	logic doPush;
	logic doPop;

	// Overflow and underflow requests are dropped
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			// Simultaneous push and pop keeps the count
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= din;
	end

	// Head is visible one cycle after push or pop
	assign dout = mem[rdPtr];
	assign full = (count == (fifoAddrBits + 1)'(depth));
	assign empty = (count == '0);

	assert property (@(posedge clk) disable iff (rst)
		count <= (fifoAddrBits + 1)'(depth))
	else $error("FIFO count above depth");

endmodule

`default_nettype wire

//--- logic/ps2FrameTransmitter.sv
`timescale 1ns/1ns
`default_nettype none

module ps2FrameTransmitter
	import ps2LinePkg::*;
#(
	parameter int inhibitCycles = 2500
)(
	input logic clk,
	input logic rst,
	input logic sendStrobe,
	input ps2Byte txByte,
	input logic fallStrobe,
	input logic clkLevel,
	input logic datLevel,
	output logic ps2ClkLow,
	output logic ps2DatLow,
	output logic txBusy
);

	localparam int cntW = $clog2(inhibitCycles + 1);

	txState state;
	logic [cntW-1:0] holdCnt;
	logic [2:0] bitCnt;
	ps2Byte shiftReg;
	logic parityBit;

	////////////////////////////////////////
	// Host to device FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= txIdle;
			holdCnt <= '0;
			bitCnt <= '0;
		end
		else
		begin
			case (state)
				txIdle:
				begin
					if (sendStrobe)
					begin
						state <= txInhibit;
						holdCnt <= '0;
					end
				end
				// Clock held low to claim the bus
				txInhibit:
				begin
					holdCnt <= holdCnt + 1'b1;
					if (holdCnt == cntW'(inhibitCycles - 1))
						state <= txStartBit;
				end
				// Data low, clock released; device starts clocking
				txStartBit:
				begin
					if (fallStrobe)
					begin
						state <= txDataBits;
						bitCnt <= '0;
					end
				end
				txDataBits:
				begin
					if (fallStrobe)
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							state <= txParityBit;
					end
				end
				txParityBit:
					if (fallStrobe)
						state <= txStopBit;
				// Stop bit is the released line
				txStopBit:
					if (fallStrobe)
						state <= txWaitAck;
				// Device pulls data low to acknowledge
				txWaitAck:
					if (!datLevel)
						state <= txWaitRelease;
				// Both lines back high ends the transfer
				txWaitRelease:
					if (clkLevel && datLevel)
						state <= txIdle;
				default:
					state <= txIdle;
			endcase
		end
	end

	// Latch byte and odd parity, shift on each presented data bit
	always_ff @(posedge clk)
	begin
		if (state == txIdle && sendStrobe)
		begin
			shiftReg <= txByte;
			parityBit <= ~^txByte;
		end
		else if (state == txDataBits && fallStrobe)
			shiftReg <= {1'b0, shiftReg[7:1]};
	end

	// Open drain style pull-low drives
	assign ps2ClkLow = (state == txInhibit);
	assign ps2DatLow = (state == txStartBit) ||
		(state == txDataBits && !shiftReg[0]) ||
		(state == txParityBit && !parityBit);
	assign txBusy = (state != txIdle);

	// Request-to-send hold lasts exactly inhibitCycles
	assert property (@(posedge clk) disable iff (rst)
		$fell(ps2ClkLow) |->
			$past(ps2ClkLow, inhibitCycles) && !$past(ps2ClkLow, inhibitCycles + 1))
	else $error("ps2ClkLow hold differs from inhibitCycles");

endmodule

`default_nettype wire

//--- logic/ps2FrameReceiver.sv
`timescale 1ns/1ns
`default_nettype none

module ps2FrameReceiver
	import ps2LinePkg::*;
(
	input logic clk,
	input logic rst,
	input logic fallStrobe,
	input logic datLevel,
	input logic txBusy,
	output ps2Byte rxByte,
	output logic rxStrobe,
	output logic parityStrobe,
	output logic framingStrobe
);

	rxState state;
	logic [2:0] bitCnt;
	ps2Byte shiftReg;
	logic parityBit;

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= rxIdle;
			bitCnt <= '0;
			rxStrobe <= 1'b0;
			parityStrobe <= 1'b0;
			framingStrobe <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			rxStrobe <= 1'b0;
			parityStrobe <= 1'b0;
			framingStrobe <= 1'b0;
			// Host owns the lines while sending
			if (txBusy)
				state <= rxIdle;
			else if (fallStrobe)
			begin
				case (state)
					rxIdle:
					begin
						// Start bit must be zero, else a glitch
						if (!datLevel)
						begin
							state <= rxDataBits;
							bitCnt <= '0;
						end
					end
					rxDataBits:
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							state <= rxParityBit;
					end
					rxParityBit:
						state <= rxStopBit;
					rxStopBit:
					begin
						state <= rxIdle;
						// Framing error wins over parity
						if (!datLevel)
							framingStrobe <= 1'b1;
						else if (!(^{shiftReg, parityBit}))
							parityStrobe <= 1'b1;
						else
							rxStrobe <= 1'b1;
					end
					default:
						state <= rxIdle;
				endcase
			end
		end
	end

	// Payload, LSB arrives first
	always_ff @(posedge clk)
	begin
		if (fallStrobe && !txBusy)
		begin
			if (state == rxDataBits)
				shiftReg <= {datLevel, shiftReg[7:1]};
			if (state == rxParityBit)
				parityBit <= datLevel;
		end
	end

	// Held stable until the next frame starts shifting
	assign rxByte = shiftReg;

	// A byte is either delivered or flagged, never both
	assert property (@(posedge clk) disable iff (rst)
		rxStrobe |-> !(parityStrobe || framingStrobe))
	else $error("rxStrobe together with an error strobe");

endmodule

`default_nettype wire

//--- logic/ps2LineFilter.sv
`timescale 1ns/1ns
`default_nettype none

module ps2LineFilter #(
	parameter int filterLength = 4
)(
	input logic clk,
	input logic rst,
	input logic ps2Clk,
	input logic ps2Dat,
	output logic clkLevel,
	output logic datLevel,
	output logic fallStrobe
);

	localparam int cntW = $clog2(filterLength + 1);

	// Index 0 is the clock line, index 1 the data line
	logic [1:0] syncA;
	logic [1:0] syncB;
	logic [1:0] level;
	logic [cntW-1:0] cnt [2];
	logic clkPrev;

	// Two flop synchronizers, idle high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			syncA <= 2'b11;
			syncB <= 2'b11;
		end
		else
		begin
			syncA <= {ps2Dat, ps2Clk};
			syncB <= syncA;
		end
	end

	// Accept a new level after filterLength equal samples
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			level <= 2'b11;
			cnt[0] <= '0;
			cnt[1] <= '0;
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (syncB[i] == level[i])
					cnt[i] <= '0;
				else if (cnt[i] == cntW'(filterLength - 1))
				begin
					level[i] <= syncB[i];
					cnt[i] <= '0;
				end
				else
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	// Previous accepted clock level for edge detect
	always_ff @(posedge clk)
	begin
		if (rst)
			clkPrev <= 1'b1;
		else
			clkPrev <= level[0];
	end

	assign clkLevel = level[0];
	assign datLevel = level[1];
	// High for one cycle per accepted falling clock edge
	assign fallStrobe = clkPrev & ~level[0];

endmodule

`default_nettype wire

//--- logic/ps2RegPkg.sv
`default_nettype none

// Bus side register map of the PS/2 port
package ps2RegPkg;

	// Sticky flags, parity lowest
	typedef logic [2:0] ps2ErrFlags;

	// Bus data word and its byte write enables
	typedef logic [31:0] busWord;
	typedef logic [3:0] byteEnable;

	// Flag positions inside ps2ErrFlags
	localparam int errParityBit = 0;
	localparam int errFramingBit = 1;
	localparam int errOverrunBit = 2;

	// Control register layout
	// RX fill count
	localparam int ctrlRxLoadLsb = 0;
	// TX fill count
	localparam int ctrlTxLoadLsb = 8;
	// Error flags, three bits
	localparam int ctrlErrLsb = 16;
	// Interrupt enable
	localparam int ctrlIntEnBit = 31;

endpackage

`default_nettype wire

//--- logic/ps2LinePkg.sv
`default_nettype none

// PS/2 line and frame level definitions
package ps2LinePkg;

	// One data byte carried by a frame
	typedef logic [7:0] ps2Byte;

	// Device to host frame
	// Start bit is consumed in idle
	typedef enum logic [1:0]
	{
		rxIdle,
		rxDataBits,
		rxParityBit,
		rxStopBit
	} rxState;

	// Host to device frame, request-to-send first
	typedef enum logic [2:0]
	{
		txIdle,
		txInhibit,
		txStartBit,
		txDataBits,
		txParityBit,
		txStopBit,
		txWaitAck,
		txWaitRelease
	} txState;

endpackage

`default_nettype wire
